//--- rtl/systolic_pe_pkg.sv
package systolic_pe_pkg;

  // Operand width on left and top streams
  localparam int OPERAND_W = 16;

  // Running partial sum width, arithmetic wraps at this size
  localparam int PSUM_W = 32;

  // Full signed product of two operands
  localparam int PRODUCT_W = 32;

  // One beat on left, right, top or bottom stream
  typedef struct packed {
    logic signed [OPERAND_W-1:0] data;
    // Marks final element of a vector
    logic                        last;
  } operand_beat_t;

  // One finished result on the down stream
  typedef struct packed {
    logic signed [PSUM_W-1:0] data;
    logic                     last;
  } psum_beat_t;

  // Paired operation handed to the MAC
  typedef struct packed {
    // Left operand (row data)
    logic signed [OPERAND_W-1:0] left;
    // Top operand (column data)
    logic signed [OPERAND_W-1:0] top;
    // Taken from the left beat
    logic                        last;
  } mac_op_t;

endpackage

//--- rtl/stream_skid_buffer.sv
module stream_skid_buffer #(
  // Payload carried through the buffer
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,

  // Upstream side
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,

  // Downstream side
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  // Main entry drives the output, skid entry catches a beat during a stall
  payload_t main_data;
  payload_t skid_data;
  logic     main_valid;
  logic     skid_valid;

  // Next-state control
  logic     main_valid_d;
  logic     skid_valid_d;
  logic     load_main_in;
  logic     load_main_skid;
  logic     load_skid;
  logic     in_fire;

  assign in_fire   = in_valid & in_ready;
  assign out_data  = main_data;
  assign out_valid = main_valid;

  always_comb begin
    main_valid_d   = main_valid;
    skid_valid_d   = skid_valid;
    load_main_in   = 1'b0;
    load_main_skid = 1'b0;
    load_skid      = 1'b0;
    // Main entry free or draining this cycle
    if (!main_valid || out_ready) begin
      if (skid_valid) begin
        // Skid holds the older beat, it goes first
        load_main_skid = 1'b1;
        main_valid_d   = 1'b1;
        skid_valid_d   = 1'b0;
      end else begin
        load_main_in = in_fire;
        main_valid_d = in_fire;
      end
    end else if (in_fire) begin
      // Output stalled, park incoming beat
      load_skid    = 1'b1;
      skid_valid_d = 1'b1;
    end
  end

  // Control flops, ready comes straight from a register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b1;
    end else begin
      main_valid <= main_valid_d;
      skid_valid <= skid_valid_d;
      // Accept again once skid entry is empty
      in_ready   <= ~skid_valid_d;
    end
  end

  // Payload flops
  always_ff @(posedge clk) begin
    if (load_main_skid) begin
      main_data <= skid_data;
    end else if (load_main_in) begin
      main_data <= in_data;
    end
    if (load_skid) begin
      skid_data <= in_data;
    end
  end

endmodule

//--- rtl/operand_pairing.sv
module operand_pairing (
  input  logic                          clk,
  input  logic                          rst_n,

  // Left operand input
  input  systolic_pe_pkg::operand_beat_t left_data,
  input  logic                          left_valid,
  output logic                          left_ready,

  // Top operand input
  input  systolic_pe_pkg::operand_beat_t top_data,
  input  logic                          top_valid,
  output logic                          top_ready,

  // Left beats forwarded to the right neighbour
  output systolic_pe_pkg::operand_beat_t right_data,
  output logic                          right_valid,
  input  logic                          right_ready,

  // Top beats forwarded to the bottom neighbour
  output systolic_pe_pkg::operand_beat_t bottom_data,
  output logic                          bottom_valid,
  input  logic                          bottom_ready,

  // Paired operation towards the MAC
  output systolic_pe_pkg::mac_op_t      op_data,
  output logic                          op_valid,
  input  logic                          op_ready,

  // Sticky flag for a pair with mismatched last bits
  output logic                          err_unaligned
);

  // Both operands present
  logic pair_avail;
  // Joint transfer on all five streams
  logic fire;
  // Last bits of the current pair differ
  logic last_mismatch;

  assign pair_avail    = left_valid & top_valid;
  assign fire          = pair_avail & right_ready & bottom_ready & op_ready;
  assign last_mismatch = left_data.last ^ top_data.last;

  // Inputs consumed only on a joint transfer
  assign left_ready = fire;
  assign top_ready  = fire;

  // Forward beats unchanged
  assign right_data  = left_data;
  assign bottom_data = top_data;

  // Each valid waits for the other two sinks, never on its own ready
  assign right_valid  = pair_avail & bottom_ready & op_ready;
  assign bottom_valid = pair_avail & right_ready & op_ready;
  assign op_valid     = pair_avail & right_ready & bottom_ready;

  // Build the MAC operation
  assign op_data.left = left_data.data;
  assign op_data.top  = top_data.data;
  // Left stream decides where a vector ends
  assign op_data.last = left_data.last;

  // Error held until reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_unaligned <= 1'b0;
    end else if (fire && last_mismatch) begin
      err_unaligned <= 1'b1;
    end
  end

endmodule

//--- rtl/mac_pipeline.sv
module mac_pipeline (
  input  logic                       clk,
  input  logic                       rst_n,

  // Paired operands in
  input  systolic_pe_pkg::mac_op_t   op_data,
  input  logic                       op_valid,
  output logic                       op_ready,

  // Finished sum out
  output systolic_pe_pkg::psum_beat_t sum_data,
  output logic                       sum_valid,
  input  logic                       sum_ready
);

  // Stage 1 registers
  logic signed [systolic_pe_pkg::PRODUCT_W-1:0] s1_product;
  logic                                         s1_valid;
  logic                                         s1_last;

  // Stage 2 running sum
  logic signed [systolic_pe_pkg::PSUM_W-1:0]    acc;

  // Combinational helpers
  logic signed [systolic_pe_pkg::PRODUCT_W-1:0] product;
  logic signed [systolic_pe_pkg::PSUM_W-1:0]    acc_next;
  logic                                         advance;
  logic                                         in_fire;

  // Whole pipe moves only when the result slot can take a sum
  assign advance  = ~sum_valid | sum_ready;
  assign op_ready = advance;
  assign in_fire  = op_valid & advance;

  // Signed 16x16 multiply at full product width
  assign product = systolic_pe_pkg::PRODUCT_W'(op_data.left)
                   * systolic_pe_pkg::PRODUCT_W'(op_data.top);

  // Product sign extended into the accumulator and wrapped at PSUM_W
  assign acc_next = acc + systolic_pe_pkg::PSUM_W'(s1_product);

  // Stage 1 valid and last
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s1_last  <= 1'b0;
    end else if (advance) begin
      s1_valid <= in_fire;
      s1_last  <= op_data.last;
    end
  end

  // Stage 1 product
  always_ff @(posedge clk) begin
    if (in_fire) begin
      s1_product <= product;
    end
  end

  // Stage 2 accumulate and result valid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc       <= '0;
      sum_valid <= 1'b0;
    end else if (advance) begin
      sum_valid <= s1_valid & s1_last;
      if (s1_valid) begin
        // Last item closes the vector and the next one starts from zero
        acc <= s1_last ? '0 : acc_next;
      end
    end
  end

  // Result payload
  always_ff @(posedge clk) begin
    if (advance && s1_valid && s1_last) begin
      sum_data.data <= acc_next;
      sum_data.last <= s1_last;
    end
  end

endmodule

//--- rtl/psum_output_stage.sv
module psum_output_stage (
  input  logic                        clk,
  input  logic                        rst_n,

  // Sums from the MAC
  input  systolic_pe_pkg::psum_beat_t sum_data,
  input  logic                        sum_valid,
  output logic                        sum_ready,

  // Down stream towards the next row
  output systolic_pe_pkg::psum_beat_t down_data,
  output logic                        down_valid,
  input  logic                        down_ready
);

  // Two entries of slack, stalls the MAC once both are taken
  stream_skid_buffer #(
    .payload_t (systolic_pe_pkg::psum_beat_t)
  ) down_buf_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (sum_data),
    .in_valid  (sum_valid),
    .in_ready  (sum_ready),
    .out_data  (down_data),
    .out_valid (down_valid),
    .out_ready (down_ready)
  );

endmodule

//--- rtl/systolic_pe.sv
module systolic_pe (
  input  logic                           clk,
  input  logic                           rst_n,

  // Left operand stream in
  input  systolic_pe_pkg::operand_beat_t s_left_data,
  input  logic                           s_left_valid,
  output logic                           s_left_ready,

  // Top operand stream in
  input  systolic_pe_pkg::operand_beat_t s_top_data,
  input  logic                           s_top_valid,
  output logic                           s_top_ready,

  // Right operand stream out
  output systolic_pe_pkg::operand_beat_t m_right_data,
  output logic                           m_right_valid,
  input  logic                           m_right_ready,

  // Bottom operand stream out
  output systolic_pe_pkg::operand_beat_t m_bottom_data,
  output logic                           m_bottom_valid,
  input  logic                           m_bottom_ready,

  // Finished partial sums out
  output systolic_pe_pkg::psum_beat_t    m_down_data,
  output logic                           m_down_valid,
  input  logic                           m_down_ready,

  output logic                           err_unaligned
);

  // Buffered left and top streams
  systolic_pe_pkg::operand_beat_t left_data;
  logic                           left_valid;
  logic                           left_ready;
  systolic_pe_pkg::operand_beat_t top_data;
  logic                           top_valid;
  logic                           top_ready;

  // Forwarded streams before output buffers
  systolic_pe_pkg::operand_beat_t right_data;
  logic                           right_valid;
  logic                           right_ready;
  systolic_pe_pkg::operand_beat_t bottom_data;
  logic                           bottom_valid;
  logic                           bottom_ready;

  // Pairing to MAC
  systolic_pe_pkg::mac_op_t       op_data;
  logic                           op_valid;
  logic                           op_ready;

  // MAC to output stage
  systolic_pe_pkg::psum_beat_t    sum_data;
  logic                           sum_valid;
  logic                           sum_ready;

  // Input side
  stream_skid_buffer #(
    .payload_t (systolic_pe_pkg::operand_beat_t)
  ) left_in_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (s_left_data),
    .in_valid  (s_left_valid),
    .in_ready  (s_left_ready),
    .out_data  (left_data),
    .out_valid (left_valid),
    .out_ready (left_ready)
  );

  stream_skid_buffer #(
    .payload_t (systolic_pe_pkg::operand_beat_t)
  ) top_in_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (s_top_data),
    .in_valid  (s_top_valid),
    .in_ready  (s_top_ready),
    .out_data  (top_data),
    .out_valid (top_valid),
    .out_ready (top_ready)
  );

  // Join, forward and check alignment
  operand_pairing pairing_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .left_data     (left_data),
    .left_valid    (left_valid),
    .left_ready    (left_ready),
    .top_data      (top_data),
    .top_valid     (top_valid),
    .top_ready     (top_ready),
    .right_data    (right_data),
    .right_valid   (right_valid),
    .right_ready   (right_ready),
    .bottom_data   (bottom_data),
    .bottom_valid  (bottom_valid),
    .bottom_ready  (bottom_ready),
    .op_data       (op_data),
    .op_valid      (op_valid),
    .op_ready      (op_ready),
    .err_unaligned (err_unaligned)
  );

  // Output side for forwarded operands
  stream_skid_buffer #(
    .payload_t (systolic_pe_pkg::operand_beat_t)
  ) right_out_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (right_data),
    .in_valid  (right_valid),
    .in_ready  (right_ready),
    .out_data  (m_right_data),
    .out_valid (m_right_valid),
    .out_ready (m_right_ready)
  );

  stream_skid_buffer #(
    .payload_t (systolic_pe_pkg::operand_beat_t)
  ) bottom_out_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (bottom_data),
    .in_valid  (bottom_valid),
    .in_ready  (bottom_ready),
    .out_data  (m_bottom_data),
    .out_valid (m_bottom_valid),
    .out_ready (m_bottom_ready)
  );

  // Multiply and accumulate
  mac_pipeline mac_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .op_data   (op_data),
    .op_valid  (op_valid),
    .op_ready  (op_ready),
    .sum_data  (sum_data),
    .sum_valid (sum_valid),
    .sum_ready (sum_ready)
  );

  // Down stream buffering
  psum_output_stage psum_out_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .sum_data   (sum_data),
    .sum_valid  (sum_valid),
    .sum_ready  (sum_ready),
    .down_data  (m_down_data),
    .down_valid (m_down_valid),
    .down_ready (m_down_ready)
  );

endmodule

//--- tb/pe_checker.sv
module pe_checker (
  input  logic                           clk,
  input  logic                           rst_n,
  input  systolic_pe_pkg::operand_beat_t s_left_data,
  input  logic                           s_left_valid,
  input  logic                           s_left_ready,
  input  systolic_pe_pkg::operand_beat_t s_top_data,
  input  logic                           s_top_valid,
  input  logic                           s_top_ready,
  input  systolic_pe_pkg::operand_beat_t m_right_data,
  input  logic                           m_right_valid,
  input  logic                           m_right_ready,
  input  systolic_pe_pkg::operand_beat_t m_bottom_data,
  input  logic                           m_bottom_valid,
  input  logic                           m_bottom_ready,
  input  systolic_pe_pkg::psum_beat_t    m_down_data,
  input  logic                           m_down_valid,
  input  logic                           m_down_ready,
  input  logic                           err_unaligned,
  output int                             error_count,
  output int                             result_count,
  output int                             pending
);

  // Longest vector the stimulus produces
  localparam int MAX_LEN = 8;

  // Beats seen on the inputs, waiting for a partner
  systolic_pe_pkg::operand_beat_t left_in_q[$];
  systolic_pe_pkg::operand_beat_t top_in_q[$];
  // Expected forwarded beats and finished sums, oldest first
  systolic_pe_pkg::operand_beat_t right_exp_q[$];
  systolic_pe_pkg::operand_beat_t bottom_exp_q[$];
  logic [systolic_pe_pkg::PSUM_W-1:0] sum_exp_q[$];

  // Vector being collected
  logic signed [systolic_pe_pkg::OPERAND_W-1:0] cur_left [MAX_LEN];
  logic signed [systolic_pe_pkg::OPERAND_W-1:0] cur_top [MAX_LEN];
  int cur_n = 0;

  int errors = 0;
  int results = 0;
  int pending_beats = 0;
  // Some pair had differing last bits
  logic misalign_seen = 1'b0;
  // err_unaligned was high at an earlier sample
  logic err_latched = 1'b0;

  assign error_count  = errors;
  assign result_count = results;
  assign pending      = pending_beats;

  // Signed dot product, wraps like a 32-bit accumulator
  function automatic logic [systolic_pe_pkg::PSUM_W-1:0] dot_product(
    input logic signed [systolic_pe_pkg::OPERAND_W-1:0] a [MAX_LEN],
    input logic signed [systolic_pe_pkg::OPERAND_W-1:0] b [MAX_LEN],
    input int n
  );
    int sum;
    int i;
    sum = 0;
    for (i = 0; i < n; i++) begin
      sum = sum + int'(a[i]) * int'(b[i]);
    end
    return sum;
  endfunction

  task automatic value_error(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    $display("** Error %s: expected %h, got %h at time %0t", name, expected, actual, $time);
    errors++;
  endtask

  task automatic protocol_error(input string what);
    $display("Failure at time %0t: %s", $time, what);
    errors++;
  endtask

  // Sampled mid-cycle, values match those at the next rising edge
  always @(negedge clk) begin
    systolic_pe_pkg::operand_beat_t lbeat;
    systolic_pe_pkg::operand_beat_t tbeat;
    systolic_pe_pkg::operand_beat_t exp_beat;
    logic [systolic_pe_pkg::PSUM_W-1:0] exp_sum;
    if (!rst_n) begin
      // Nothing may leave the node while in reset
      if (m_right_valid || m_bottom_valid || m_down_valid || err_unaligned) begin
        protocol_error("an output valid or err_unaligned is high during reset");
      end
    end else begin
      // Input transfers
      if (s_left_valid && s_left_ready) begin
        left_in_q.push_back(s_left_data);
        right_exp_q.push_back(s_left_data);
      end
      if (s_top_valid && s_top_ready) begin
        top_in_q.push_back(s_top_data);
        bottom_exp_q.push_back(s_top_data);
      end
      // Pair beats in arrival order, left last closes a vector
      while (left_in_q.size() > 0 && top_in_q.size() > 0) begin
        lbeat = left_in_q.pop_front();
        tbeat = top_in_q.pop_front();
        if (lbeat.last != tbeat.last) begin
          misalign_seen = 1'b1;
        end
        if (cur_n < MAX_LEN) begin
          cur_left[cur_n] = lbeat.data;
          cur_top[cur_n]  = tbeat.data;
          cur_n++;
        end else begin
          protocol_error("a left vector is longer than eight beats");
        end
        if (lbeat.last) begin
          sum_exp_q.push_back(dot_product(cur_left, cur_top, cur_n));
          cur_n = 0;
        end
      end
      // Forwarded operands, exact copies in order
      if (m_right_valid && m_right_ready) begin
        if (right_exp_q.size() == 0) begin
          protocol_error("m_right sent a beat that never entered on s_left");
        end else begin
          exp_beat = right_exp_q.pop_front();
          if (m_right_data !== exp_beat) begin
            value_error("m_right_data", 32'(exp_beat), 32'(m_right_data));
          end
        end
      end
      if (m_bottom_valid && m_bottom_ready) begin
        if (bottom_exp_q.size() == 0) begin
          protocol_error("m_bottom sent a beat that never entered on s_top");
        end else begin
          exp_beat = bottom_exp_q.pop_front();
          if (m_bottom_data !== exp_beat) begin
            value_error("m_bottom_data", 32'(exp_beat), 32'(m_bottom_data));
          end
        end
      end
      // Finished sums
      if (m_down_valid && m_down_ready) begin
        results++;
        if (sum_exp_q.size() == 0) begin
          protocol_error("m_down sent a result with no finished vector pending");
        end else begin
          exp_sum = sum_exp_q.pop_front();
          if (m_down_data.data !== exp_sum) begin
            value_error("m_down_data.data", exp_sum, m_down_data.data);
          end
          if (m_down_data.last !== 1'b1) begin
            value_error("m_down_data.last", 32'd1, 32'(m_down_data.last));
          end
        end
      end
      // Sticky error flag
      if (err_unaligned && !misalign_seen) begin
        protocol_error("err_unaligned is set but no pair had mismatched last bits");
      end
      if (err_latched && !err_unaligned) begin
        protocol_error("err_unaligned cleared after it had been set");
      end
      err_latched = err_latched | err_unaligned;
    end
    pending_beats = left_in_q.size() + top_in_q.size() + cur_n + right_exp_q.size()
                    + bottom_exp_q.size() + sum_exp_q.size();
  end

endmodule

//--- tb/systolic_pe_tb.sv
module systolic_pe_tb;

  // Vector counts per phase
  localparam int NUM_BURST   = 10;
  localparam int NUM_RANDOM  = 30;
  // Cycles allowed for one beat or for draining
  localparam int WAIT_LIMIT  = 200;
  localparam int DRAIN_LIMIT = 1000;

  logic clk = 1'b0;
  logic rst_n;

  systolic_pe_pkg::operand_beat_t s_left_data;
  logic                           s_left_valid;
  logic                           s_left_ready;
  systolic_pe_pkg::operand_beat_t s_top_data;
  logic                           s_top_valid;
  logic                           s_top_ready;
  systolic_pe_pkg::operand_beat_t m_right_data;
  logic                           m_right_valid;
  logic                           m_right_ready;
  systolic_pe_pkg::operand_beat_t m_bottom_data;
  logic                           m_bottom_valid;
  logic                           m_bottom_ready;
  systolic_pe_pkg::psum_beat_t    m_down_data;
  logic                           m_down_valid;
  logic                           m_down_ready;
  logic                           err_unaligned;

  // Checker results
  int error_count;
  int result_count;
  int pending;

  integer seed = 34288;
  int     stim_errors;
  // Random ready on all outputs when set
  logic   ready_random;

  // Stimulus built before reset, one entry per beat
  systolic_pe_pkg::operand_beat_t left_beats[$];
  systolic_pe_pkg::operand_beat_t top_beats[$];
  int left_gaps[$];
  int top_gaps[$];
  // Length of each vector sent
  int vec_lens[$];

  always #2 clk = ~clk;

  systolic_pe i_systolic_pe (.*);

  pe_checker checker_inst (.*);

  // Append one vector to both streams
  task automatic add_vector(input int len, input bit extreme, input bit skewed, input bit gaps);
    systolic_pe_pkg::operand_beat_t lbeat;
    systolic_pe_pkg::operand_beat_t tbeat;
    int i;
    for (i = 0; i < len; i++) begin
      // Most negative operand pushes the sum past 2^32
      lbeat.data = extreme ? 16'h8000 : systolic_pe_pkg::OPERAND_W'($random(seed));
      tbeat.data = extreme ? 16'h8000 : systolic_pe_pkg::OPERAND_W'($random(seed));
      lbeat.last = (i == len - 1);
      // Skewed top closes its vector on the first beat
      tbeat.last = skewed ? (i == 0) : (i == len - 1);
      left_beats.push_back(lbeat);
      top_beats.push_back(tbeat);
      left_gaps.push_back(gaps ? ($random(seed) & 3) >> 1 : 0);
      top_gaps.push_back(gaps ? ($random(seed) & 3) >> 1 : 0);
    end
    vec_lens.push_back(len);
  endtask

  // Send beats first..stop-1 of one input stream
  task automatic drive_stream(input bit is_top, input int first, input int stop);
    int  idx;
    int  waited;
    bit  taken;
    for (idx = first; idx < stop && stim_errors == 0; idx++) begin
      repeat (is_top ? top_gaps[idx] : left_gaps[idx]) begin
        @(posedge clk);
        #1;
      end
      if (is_top) begin
        s_top_data  = top_beats[idx];
        s_top_valid = 1'b1;
      end else begin
        s_left_data  = left_beats[idx];
        s_left_valid = 1'b1;
      end
      taken  = 1'b0;
      waited = 0;
      while (!taken && waited < WAIT_LIMIT) begin
        // Ready seen here holds at the coming edge
        @(negedge clk);
        taken = is_top ? s_top_ready : s_left_ready;
        @(posedge clk);
        #1;
        waited++;
      end
      if (is_top) begin
        s_top_valid = 1'b0;
      end else begin
        s_left_valid = 1'b0;
      end
      if (!taken) begin
        $display("Timeout: %s beat %0d was never accepted", is_top ? "top" : "left", idx);
        stim_errors++;
      end
    end
  endtask

  // Output ready pattern
  initial begin
    m_right_ready  = 1'b1;
    m_bottom_ready = 1'b1;
    m_down_ready   = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      if (ready_random) begin
        m_right_ready  = ($random(seed) & 3) != 0;
        m_bottom_ready = ($random(seed) & 3) != 0;
        m_down_ready   = ($random(seed) & 1) != 0;
      end else begin
        m_right_ready  = 1'b1;
        m_bottom_ready = 1'b1;
        m_down_ready   = 1'b1;
      end
    end
  end

  initial begin
    int i;
    int burst_end;
    int waited;
    rst_n        = 1'b0;
    s_left_data  = '0;
    s_left_valid = 1'b0;
    s_top_data   = '0;
    s_top_valid  = 1'b0;
    stim_errors  = 0;
    ready_random = 1'b0;
    // Back to back vectors, first one wraps the accumulator
    add_vector(5, 1'b1, 1'b0, 1'b0);
    for (i = 1; i < NUM_BURST; i++) begin
      add_vector(1 + ($random(seed) & 7), 1'b0, 1'b0, 1'b0);
    end
    burst_end = left_beats.size();
    for (i = 0; i < NUM_RANDOM; i++) begin
      add_vector(1 + ($random(seed) & 7), 1'b0, 1'b0, 1'b1);
    end
    // Final vector with disagreeing last bits
    add_vector(3, 1'b0, 1'b1, 1'b1);

    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    fork
      drive_stream(1'b0, 0, burst_end);
      drive_stream(1'b1, 0, burst_end);
    join
    @(negedge clk);
    ready_random = 1'b1;
    @(posedge clk);
    #1;
    fork
      drive_stream(1'b0, burst_end, left_beats.size());
      drive_stream(1'b1, burst_end, top_beats.size());
    join

    // Drain with all outputs ready
    @(negedge clk);
    ready_random = 1'b0;
    @(posedge clk);
    waited = 0;
    while (pending != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (pending != 0) begin
      $display("Timeout: %0d expected beats never left the DUT", pending);
      stim_errors++;
    end
    if (result_count != vec_lens.size()) begin
      $display("Got %0d results for %0d vectors sent", result_count, vec_lens.size());
      stim_errors++;
    end
    @(negedge clk);
    if (err_unaligned !== 1'b1) begin
      $display("** Error err_unaligned: expected %h, got %h", 1'b1, err_unaligned);
      stim_errors++;
    end

    $display("Summary: %0d vectors, %0d results, %0d checker errors, %0d testbench errors",
             vec_lens.size(), result_count, error_count, stim_errors);
    if (error_count == 0 && stim_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- systolic_pe.f
rtl/systolic_pe_pkg.sv
rtl/stream_skid_buffer.sv
rtl/operand_pairing.sv
rtl/mac_pipeline.sv
rtl/psum_output_stage.sv
rtl/systolic_pe.sv
tb/pe_checker.sv
tb/systolic_pe_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the systolic_pe testbench with Verilator
cd "$(dirname "$0")" &&
  verilator --binary --timing -j 0 --top-module systolic_pe_tb -f systolic_pe.f &&
  ./obj_dir/Vsystolic_pe_tb | tee /dev/stderr | grep -q "^TEST PASSED$" &&
  echo "Simulation run succeeded" ||
  { echo "Simulation run failed"; exit 1; }
